// File: hdl/raster_bus_pkg.sv
package raster_bus_pkg;

    // ------------------------------------------------------------------
    // Memory read port, pipelined with waitrequest and readdatavalid.
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [25:0] address;
        logic        read;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] readdata;
        logic        readdatavalid;
        logic        waitrequest;
    } mem_rsp_t;

    // ------------------------------------------------------------------
    // Wishbone classic register port.
    // ------------------------------------------------------------------

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Byte offsets of the register map.
    localparam logic [3:0] REG_CTRL   = 4'd0;
    localparam logic [3:0] REG_BASE   = 4'd4;
    localparam logic [3:0] REG_STATUS = 4'd8;
    localparam logic [3:0] REG_COUNT  = 4'd12;

endpackage

// File: hdl/raster_geom_pkg.sv
package raster_geom_pkg;

    // Words fetched from memory for one triangle.
    localparam int WORDS_PER_TRI = 15;

    // ------------------------------------------------------------------
    // Triangle record as handed to the rasterizer.
    // ------------------------------------------------------------------

    // Attribute order matches the word order in memory.
    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [31:0] w;
        logic [31:0] color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_record_t;

    // Raw image of one triangle, word 0 in the top slot so that a cast
    // to tri_record_t puts it into v0.x.
    typedef logic [WORDS_PER_TRI-1:0][31:0] tri_words_t;

endpackage

// File: hdl/raster_vertex_fetch.sv
`timescale 1ns/1ps

module raster_vertex_fetch
    import raster_bus_pkg::*, raster_geom_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic        clock,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output tri_record_t tri_out,
    output logic        tri_valid,
    input  logic        stall,
    output logic        done
);

    logic        start_pulse;
    logic [25:0] base_addr;
    logic [15:0] tri_count;
    logic        count_valid;
    logic        expect_header;
    logic        busy;
    logic        push;
    tri_record_t record;
    logic [15:0] delivered;
    logic        pop;
    logic        fifo_full;

    // One transfer to the rasterizer, and one credit back.
    assign pop = tri_valid & ~stall;

    vertex_fetch_regs regs_i (
        .clock       (clock),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .start_pulse (start_pulse),
        .base_addr   (base_addr),
        .tri_count   (tri_count),
        .delivered   (delivered),
        .busy        (busy),
        .done        (done)
    );

    vertex_read_master #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) master_i (
        .clock         (clock),
        .reset         (reset),
        .start_pulse   (start_pulse),
        .base_addr     (base_addr),
        .tri_count     (tri_count),
        .count_valid   (count_valid),
        .pop_event     (pop),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .expect_header (expect_header),
        .busy          (busy)
    );

    vertex_assembler assembler_i (
        .clock         (clock),
        .reset         (reset),
        .mem_rsp       (mem_rsp),
        .expect_header (expect_header),
        .tri_count     (tri_count),
        .count_valid   (count_valid),
        .push          (push),
        .record        (record),
        .delivered     (delivered),
        .pop_event     (pop)
    );

    tri_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) fifo_i (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .din       (record),
        .pop       (pop),
        .dout      (tri_out),
        .not_empty (tri_valid),
        .full      (fifo_full)
    );

endmodule

// File: hdl/tri_fifo.sv
`timescale 1ns/1ps

module tri_fifo
    import raster_geom_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        push,
    input  tri_record_t din,
    input  logic        pop,
    output tri_record_t dout,
    output logic        not_empty,
    output logic        full
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    tri_record_t              slots [0:DEPTH-1];
    logic [FIFO_DEPTH_LOG2:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;

    // Extra pointer bit tells full from empty.
    assign not_empty = (wr_ptr != rd_ptr);
    assign full      = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2])
                       && (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    // Head is always on the output.
    assign dout = slots[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

    always_ff @(posedge clock) begin
        if (push && !full) begin
            slots[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= din;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && not_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hdl/vertex_assembler.sv
`timescale 1ns/1ps

module vertex_assembler
    import raster_bus_pkg::*, raster_geom_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  mem_rsp_t    mem_rsp,
    input  logic        expect_header,
    output logic [15:0] tri_count,
    output logic        count_valid,
    output logic        push,
    output tri_record_t record,
    output logic [15:0] delivered,
    input  logic        pop_event
);

    localparam logic [3:0] LAST_WORD = 4'(WORDS_PER_TRI - 1);

    tri_words_t words;
    logic [3:0] word_idx;
    logic       header_hit;
    logic       data_hit;

    assign header_hit = mem_rsp.readdatavalid & expect_header;
    assign data_hit   = mem_rsp.readdatavalid & ~expect_header;

    // Oldest word ends in the top slot after fifteen shifts.
    assign record = tri_record_t'(words);

    always_ff @(posedge clock) begin
        if (data_hit) begin
            words <= {words[WORDS_PER_TRI-2:0], mem_rsp.readdata};
        end
    end

    // ------------------------------------------------------------------
    // Word counting, header capture and delivery count.
    // ------------------------------------------------------------------

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            word_idx    <= '0;
            push        <= 1'b0;
            tri_count   <= '0;
            count_valid <= 1'b0;
            delivered   <= '0;
        end else begin
            push <= data_hit & (word_idx == LAST_WORD);
            if (header_hit) begin
                tri_count   <= mem_rsp.readdata[15:0];
                count_valid <= 1'b1;
                delivered   <= '0;
                word_idx    <= '0;
            end else begin
                // Stale count is withdrawn while a new header is awaited.
                if (expect_header) begin
                    count_valid <= 1'b0;
                end
                if (data_hit) begin
                    word_idx <= (word_idx == LAST_WORD) ? 4'd0 : word_idx + 4'd1;
                end
                if (pop_event) begin
                    delivered <= delivered + 16'd1;
                end
            end
        end
    end

endmodule

// File: hdl/vertex_fetch_regs.sv
`timescale 1ns/1ps

module vertex_fetch_regs
    import raster_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output logic        start_pulse,
    output logic [25:0] base_addr,
    input  logic [15:0] tri_count,
    input  logic [15:0] delivered,
    input  logic        busy,
    output logic        done
);

    logic        ack_q;
    logic [31:0] rdata_q;
    logic        run_q;
    logic        wr_strobe;
    logic [31:0] byte_mask;
    logic [31:0] base_merged;
    logic [31:0] rdata_next;

    assign wb_rsp = '{ack: ack_q, dat: rdata_q};

    // Writes land on the edge that closes the ack cycle.
    assign wr_strobe = ack_q & wb_req.cyc & wb_req.stb & wb_req.we;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_mask[8*b +: 8] = {8{wb_req.sel[b]}};
        end
    end

    assign base_merged = ({6'd0, base_addr} & ~byte_mask) | (wb_req.dat & byte_mask);

    always_comb begin
        case (wb_req.adr)
            REG_BASE:   rdata_next = {6'd0, base_addr};
            REG_STATUS: rdata_next = {30'd0, done, busy};
            REG_COUNT:  rdata_next = {delivered, tri_count};
            default:    rdata_next = 32'd0;
        endcase
    end

    // ------------------------------------------------------------------
    // Bus handshake and control registers.
    // ------------------------------------------------------------------

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ack_q       <= 1'b0;
            start_pulse <= 1'b0;
            base_addr   <= '0;
            run_q       <= 1'b0;
        end else begin
            ack_q       <= wb_req.cyc & wb_req.stb & ~ack_q;
            start_pulse <= wr_strobe & (wb_req.adr == REG_CTRL) & wb_req.sel[0]
                           & wb_req.dat[0];
            if (wr_strobe && wb_req.adr == REG_BASE) begin
                base_addr <= base_merged[25:0];
            end
            if (start_pulse) begin
                run_q <= 1'b1;
            end
        end
    end

    // Read data is sampled together with the ack.
    always_ff @(posedge clock) begin
        if (wb_req.cyc && wb_req.stb && !ack_q) begin
            rdata_q <= rdata_next;
        end
    end

    // The count is known once the fetcher leaves its busy phase.
    // A new start drops the flag at once.
    assign done = run_q & ~busy & ~start_pulse & (delivered == tri_count);

endmodule

// File: hdl/vertex_read_master.sv
`timescale 1ns/1ps

module vertex_read_master
    import raster_bus_pkg::*, raster_geom_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        start_pulse,
    input  logic [25:0] base_addr,
    input  logic [15:0] tri_count,
    input  logic        count_valid,
    input  logic        pop_event,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output logic        expect_header,
    output logic        busy
);

    localparam int CREDIT_W = FIFO_DEPTH_LOG2 + 1;
    localparam logic [CREDIT_W-1:0] CREDIT_LIMIT = CREDIT_W'(1 << FIFO_DEPTH_LOG2);
    localparam logic [3:0] LAST_WORD = 4'(WORDS_PER_TRI - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_WAIT_COUNT,
        S_BURST,
        S_FINISH
    } state_t;

    state_t              state;
    logic                read_q;
    logic [25:0]         addr_q;
    logic [3:0]          word_cnt;
    logic [15:0]         issued;
    logic [CREDIT_W-1:0] credits;
    logic                accept;
    logic                last_word;
    logic                more_tris;
    logic                slot_free;
    logic                charge;

    assign mem_req = '{address: addr_q, read: read_q};

    assign accept    = read_q & ~mem_rsp.waitrequest;
    assign last_word = accept & (word_cnt == LAST_WORD);
    assign more_tris = count_valid & (issued != tri_count);
    assign slot_free = credits < CREDIT_LIMIT;

    // A new triangle starts when the bus is free or the previous one just finished.
    assign charge = (state == S_BURST) & (~read_q | last_word) & more_tris & slot_free;

    assign expect_header = (state == S_HEADER) | (state == S_WAIT_COUNT);
    assign busy          = (state != S_IDLE);

    // ------------------------------------------------------------------
    // Credits: one per triangle between first read and pop.
    // ------------------------------------------------------------------

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            credits <= '0;
        end else begin
            credits <= credits + CREDIT_W'(charge) - CREDIT_W'(pop_event);
        end
    end

    // ------------------------------------------------------------------
    // Request FSM.
    // ------------------------------------------------------------------

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= S_IDLE;
            read_q   <= 1'b0;
            addr_q   <= '0;
            word_cnt <= '0;
            issued   <= '0;
        end else begin
            if (accept) begin
                addr_q <= addr_q + 26'd4;
            end
            case (state)
                S_IDLE: begin
                    if (start_pulse) begin
                        addr_q   <= base_addr;
                        read_q   <= 1'b1;
                        word_cnt <= '0;
                        issued   <= '0;
                        state    <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (accept) begin
                        read_q <= 1'b0;
                        state  <= S_WAIT_COUNT;
                    end
                end
                S_WAIT_COUNT: begin
                    // Only the header read is outstanding here.
                    if (mem_rsp.readdatavalid) begin
                        state <= (mem_rsp.readdata[15:0] == 16'd0) ? S_IDLE : S_BURST;
                    end
                end
                S_BURST: begin
                    if (accept) begin
                        word_cnt <= last_word ? 4'd0 : word_cnt + 4'd1;
                    end
                    if (!read_q || last_word) begin
                        read_q <= charge;
                        if (charge) begin
                            issued <= issued + 16'd1;
                        end
                        if (!more_tris) begin
                            state <= S_FINISH;
                        end
                    end
                end
                S_FINISH: begin
                    // Wait for the last queued triangle to leave.
                    if (pop_event && credits == CREDIT_W'(1)) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// File: project.f
hdl/raster_bus_pkg.sv
hdl/raster_geom_pkg.sv
hdl/vertex_fetch_regs.sv
hdl/vertex_read_master.sv
hdl/vertex_assembler.sv
hdl/tri_fifo.sv
hdl/raster_vertex_fetch.sv
sim/raster_vertex_fetch_checker.sv
sim/tb_raster_vertex_fetch.sv

// File: sim/raster_vertex_fetch_checker.sv
`timescale 1ns/1ps

module raster_vertex_fetch_checker
    import raster_bus_pkg::*, raster_geom_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input mem_req_t    mem_req,
    input mem_rsp_t    mem_rsp,
    input tri_record_t tri_out,
    input logic        tri_valid,
    input logic        stall,
    input logic        ack,
    input logic        push,
    input logic        full
);

    int fail_count = 0;

    // Request is held while the memory stalls it.
    req_held: assert property (@(posedge clock) disable iff (!reset)
        mem_req.read && mem_rsp.waitrequest |=> $stable(mem_req))
    else begin
        fail_count++;
        $error("memory request changed under waitrequest");
    end

    out_held: assert property (@(posedge clock) disable iff (!reset)
        tri_valid && stall |=> tri_valid && $stable(tri_out))
    else begin
        fail_count++;
        $error("triangle output changed under stall");
    end

    ack_single: assert property (@(posedge clock) disable iff (!reset)
        ack |=> !ack)
    else begin
        fail_count++;
        $error("wishbone ack held longer than one cycle");
    end

    no_push_full: assert property (@(posedge clock) disable iff (!reset)
        push |-> !full)
    else begin
        fail_count++;
        $error("record pushed into a full FIFO");
    end

endmodule

bind raster_vertex_fetch raster_vertex_fetch_checker checker_i (
    .clock     (clock),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .tri_out   (tri_out),
    .tri_valid (tri_valid),
    .stall     (stall),
    .ack       (wb_rsp.ack),
    .push      (push),
    .full      (fifo_full)
);

// File: sim/tb_raster_vertex_fetch.sv
`timescale 1ns/1ps

module tb_raster_vertex_fetch
    import raster_bus_pkg::*, raster_geom_pkg::*;
();

    localparam int FIFO_DEPTH_LOG2 = 2;
    localparam int TOTAL_TRIS = 23;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_TRIS + 2000;

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    tri_record_t tri_out;
    logic        tri_valid;
    logic        stall;
    logic        done;

    logic [31:0] rng = 32'd39;
    string       cur_test;
    int          errors = 0;
    logic [25:0] cur_base;
    logic [15:0] cur_count;
    bit          rand_wait;
    bit          rand_stall;
    bit          header_pending;
    bit          saw_valid;
    int          data_reads;
    int          pops;
    int          cycle;
    logic [31:0] rsp_data [$];
    int          rsp_due [$];

    raster_vertex_fetch #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) raster_vertex_fetch_i (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .tri_out   (tri_out),
        .tri_valid (tri_valid),
        .stall     (stall),
        .done      (done)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word k of triangle t in the current buffer.
    function automatic logic [31:0] tri_word(input int t, input int k);
        return {cur_base[15:8], 8'(t), 8'(k), 8'hC3};
    endfunction

    function automatic logic [31:0] mem_word(input logic [25:0] addr);
        int idx;
        idx = int'((addr - cur_base) >> 2);
        if (idx == 0) begin
            return {16'd0, cur_count};
        end
        return tri_word((idx - 1) / WORDS_PER_TRI, (idx - 1) % WORDS_PER_TRI);
    endfunction

    // v0.x sits in the top bits, then the attributes of v0, v1 and v2 in order.
    function automatic logic [479:0] expected_record(input int t);
        logic [479:0] r;
        for (int k = 0; k < WORDS_PER_TRI; k++) begin
            r[479 - 32*k -: 32] = tri_word(t, k);
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            errors++;
            $display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Memory model and rasterizer sink, driven on the falling edge.
    // ------------------------------------------------------------------

    always @(negedge clock) begin
        cycle++;
        mem_rsp.readdatavalid = 1'b0;
        if (rsp_due.size() > 0 && rsp_due[0] <= cycle) begin
            mem_rsp.readdata      = rsp_data.pop_front();
            mem_rsp.readdatavalid = 1'b1;
            void'(rsp_due.pop_front());
        end
        rng = xorshift(rng);
        mem_rsp.waitrequest = rand_wait && rng[4];
        stall = rand_stall && (rng[17:15] != 3'd0);
        if (mem_req.read && !mem_rsp.waitrequest) begin
            if (header_pending) begin
                header_pending = 1'b0;
            end else begin
                assert (data_reads / WORDS_PER_TRI + 1 - pops <= (1 << FIFO_DEPTH_LOG2))
                else begin
                    errors++;
                    $display("%s: read issued while all FIFO credits were in use", cur_test);
                end
                data_reads++;
            end
            rsp_data.push_back(mem_word(mem_req.address));
            rsp_due.push_back(cycle + 1 + int'(rng[9:8]));
        end
        if (tri_valid) begin
            saw_valid = 1'b1;
        end
        if (tri_valid && !stall) begin
            assert (tri_out == expected_record(pops)) else begin
                errors++;
                $display("error %s record %0d: expected %h, actual %h",
                         cur_test, pops, expected_record(pops), tri_out);
            end
            pops++;
        end
    end

    // ------------------------------------------------------------------
    // Wishbone driver and test sequence.
    // ------------------------------------------------------------------

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata, sel: 4'hF};
        @(negedge clock);
        while (!wb_rsp.ack) begin
            @(negedge clock);
        end
        rdata = wb_rsp.dat;
        @(negedge clock);
        wb_req = '0;
    endtask

    task automatic run_buffer(input string name, input logic [25:0] base,
                              input logic [15:0] count, input bit wait_on, input bit stall_on);
        logic [31:0] ignored;
        cur_test       = name;
        cur_base       = base;
        cur_count      = count;
        rand_wait      = wait_on;
        rand_stall     = stall_on;
        header_pending = 1'b1;
        saw_valid      = 1'b0;
        data_reads     = 0;
        pops           = 0;
        wb_access(1'b1, REG_BASE, {6'd0, base}, ignored);
        wb_access(1'b1, REG_CTRL, 32'd1, ignored);
        assert (!done) else begin
            errors++;
            $display("%s: done still set after start", name);
        end
        while (!done) begin
            @(negedge clock);
        end
        check_value("delivered", 32'(count), 32'(pops));
    endtask

    initial begin
        logic [31:0] rdata;
        reset      = 1'b0;
        wb_req     = '0;
        mem_rsp    = '0;
        stall      = 1'b0;
        rand_wait  = 1'b0;
        rand_stall = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        cur_test = "register_access";
        wb_access(1'b0, REG_STATUS, 32'd0, rdata);
        check_value("status", 32'd0, rdata);
        wb_access(1'b1, REG_BASE, 32'hFEAB_CDE4, rdata);
        wb_access(1'b0, REG_BASE, 32'd0, rdata);
        check_value("base", 32'h02AB_CDE4, rdata);

        run_buffer("basic_fetch", 26'h100, 16'd3, 1'b0, 1'b0);
        run_buffer("back_pressure", 26'h2000, 16'd10, 1'b0, 1'b1);
        run_buffer("latency_wait", 26'h4000, 16'd6, 1'b1, 1'b0);
        run_buffer("zero_count", 26'h6000, 16'd0, 1'b1, 1'b1);
        check_value("tri_valid seen", 32'd0, 32'(saw_valid));
        run_buffer("restart", 26'h8000, 16'd4, 1'b1, 1'b1);
        wb_access(1'b0, REG_COUNT, 32'd0, rdata);
        check_value("count", {16'd4, 16'd4}, rdata);

        $display("data errors: %0d, assertion errors: %0d",
                 errors, raster_vertex_fetch_i.checker_i.fail_count);
        if (errors == 0 && raster_vertex_fetch_i.checker_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
